//--- design/castor_map_top.sv
`timescale 1ns/1ps

module castor_map_top #(
  parameter int GBOX_DWID    = castor_pkg::GBOX_DWID_DEF,
  parameter int FAB_GBOX_NUM = castor_pkg::FAB_GBOX_NUM_DEF
) (
  input  logic                                 clk,
  input  logic                                 rst_i,
  input  logic                                 cfg_done_i,
  // pl port
  input  logic                                 pl_init_i,
  input  logic                                 pl_ena_i,
  input  logic [1:0]                           pl_wen_i,
  input  logic                                 pl_ren_i,
  input  logic [castor_pkg::PL_AWID-1:0]       pl_addr_i,
  input  logic [castor_pkg::PL_DWID-1:0]       pl_data_i,
  output logic [castor_pkg::PL_DWID-1:0]       pl_data_o,
  // fabric side
  input  logic [GBOX_DWID*FAB_GBOX_NUM-1:0]    io_f2a_i,
  input  logic [FAB_GBOX_NUM-1:0]              io_oe_dyn_i,
  input  logic [castor_pkg::IRQ_SRC_NUM-1:0]   fab_irq_i,
  input  logic [castor_pkg::DMA_NUM-1:0]       fab_dma_req_i,
  input  logic [castor_pkg::IRQ_SET_NUM-1:0]   fab_irq_clr_i,
  output logic [GBOX_DWID*FAB_GBOX_NUM-1:0]    io_a2f_o,
  output logic [castor_pkg::IRQ_SET_NUM-1:0]   fab_irq_pend_o,
  // gearbox side
  input  logic [GBOX_DWID-1:0]                 gbox2fab_i [0:FAB_GBOX_NUM-1],
  output logic [GBOX_DWID-1:0]                 fab2gbox_o [0:FAB_GBOX_NUM-1],
  // SoC side
  input  logic [castor_pkg::IRQ_SET_NUM-1:0]   a2f_irq_set_i,
  input  logic [castor_pkg::DMA_NUM-1:0]       a2f_dma_ack_i,
  output logic [castor_pkg::IRQ_SRC_NUM-1:0]   f2a_irq_src_o,
  output logic [castor_pkg::DMA_NUM-1:0]       f2a_dma_req_o,
  // IO cell
  output logic [FAB_GBOX_NUM-1:0]              fab_io_ie_o,
  output logic [FAB_GBOX_NUM-1:0]              fab_io_oe_o,
  output logic [FAB_GBOX_NUM-1:0]              fab_io_pe_o,
  output logic [FAB_GBOX_NUM-1:0]              fab_io_pud_o,
  output logic [FAB_GBOX_NUM*2-1:0]            fab_io_aic_o,
  output logic [FAB_GBOX_NUM*2-1:0]            fab_io_ds_o,
  output logic [FAB_GBOX_NUM*2-1:0]            fab_io_sr_o,
  output logic [FAB_GBOX_NUM*2-1:0]            fab_io_mc_o
);
  import castor_pkg::*;

  pl_cmd_t                pl_cmd;
  io_ctrl_t               pad_cfg [FAB_GBOX_NUM];  // bank to IO stage
  logic [IRQ_SRC_NUM-1:0] irq_mask;
  logic [DMA_NUM-1:0]     dma_en;

  // ************************************************************
  // config bank
  // ************************************************************
  assign pl_cmd = '{init: pl_init_i, ena: pl_ena_i, wen: pl_wen_i, ren: pl_ren_i,
                    addr: pl_addr_i, data: pl_data_i};

  pl_cfg_bank #(.FAB_GBOX_NUM(FAB_GBOX_NUM)) u_pl_cfg_bank (
    .clk        (clk),
    .rst_i      (rst_i),
    .pl_cmd_i   (pl_cmd),
    .pl_data_o  (pl_data_o),
    .pad_cfg_o  (pad_cfg),
    .irq_mask_o (irq_mask),
    .dma_en_o   (dma_en)
  );

  // ************************************************************
  // output stages, all one register deep
  // ************************************************************
  io_ctrl_stage #(.FAB_GBOX_NUM(FAB_GBOX_NUM)) u_io_ctrl_stage (
    .clk          (clk),
    .rst_i        (rst_i),
    .cfg_done_i   (cfg_done_i),
    .pad_cfg_i    (pad_cfg),
    .io_oe_dyn_i  (io_oe_dyn_i),
    .fab_io_ie_o  (fab_io_ie_o),
    .fab_io_oe_o  (fab_io_oe_o),  // oe_en and dynamic enable combined
    .fab_io_pe_o  (fab_io_pe_o),
    .fab_io_pud_o (fab_io_pud_o),
    .fab_io_aic_o (fab_io_aic_o),
    .fab_io_ds_o  (fab_io_ds_o),
    .fab_io_sr_o  (fab_io_sr_o),
    .fab_io_mc_o  (fab_io_mc_o)
  );

  gbox_lane_map #(
    .GBOX_DWID    (GBOX_DWID),
    .FAB_GBOX_NUM (FAB_GBOX_NUM)
  ) u_gbox_lane_map (
    .clk        (clk),
    .rst_i      (rst_i),
    .cfg_done_i (cfg_done_i),
    .io_f2a_i   (io_f2a_i),
    .gbox2fab_i (gbox2fab_i),
    .fab2gbox_o (fab2gbox_o),
    .io_a2f_o   (io_a2f_o)
  );

  irq_dma_bridge u_irq_dma_bridge (
    .clk            (clk),
    .rst_i          (rst_i),
    .cfg_done_i     (cfg_done_i),
    .irq_mask_i     (irq_mask),
    .dma_en_i       (dma_en),
    .fab_irq_i      (fab_irq_i),
    .fab_irq_clr_i  (fab_irq_clr_i),
    .fab_dma_req_i  (fab_dma_req_i),
    .a2f_irq_set_i  (a2f_irq_set_i),
    .a2f_dma_ack_i  (a2f_dma_ack_i),
    .f2a_irq_src_o  (f2a_irq_src_o),
    .fab_irq_pend_o (fab_irq_pend_o),
    .f2a_dma_req_o  (f2a_dma_req_o)
  );

endmodule

//--- design/castor_pkg.sv
package castor_pkg;

  // ************************************************************
  // size defaults, the top level passes these down
  // ************************************************************
  localparam int GBOX_DWID_DEF    = 8;  // bits per gearbox lane
  localparam int FAB_GBOX_NUM_DEF = 4;  // gearbox lanes, one pad each

  localparam int IRQ_SRC_NUM = 16;  // fabric to SoC interrupts
  localparam int IRQ_SET_NUM = 12;  // SoC to fabric interrupts
  localparam int DMA_NUM     = 4;   // dma channels

  localparam int PL_DWID = 36;
  localparam int PL_AWID = 32;
  localparam int PL_HWID = PL_DWID / 2;  // one pl_wen half

  // ************************************************************
  // per-pad IO cell setting
  // ************************************************************
  typedef struct packed {
    logic       oe_en;  // lets the dynamic oe through
    logic       ie;
    logic       pe;
    logic       pud;
    logic [1:0] aic;
    logic [1:0] ds;
    logic [1:0] sr;
    logic [1:0] mc;
  } io_ctrl_t;

  localparam int IO_CTRL_W = $bits(io_ctrl_t);  // 12, sits in half 0

  // ************************************************************
  // one parallel-load access
  // ************************************************************
  typedef struct packed {
    logic               init;  // clears the whole bank
    logic               ena;
    logic [1:0]         wen;   // one bit per 18-bit half
    logic               ren;
    logic [PL_AWID-1:0] addr;
    logic [PL_DWID-1:0] data;
  } pl_cmd_t;

  // word addresses
  localparam logic [PL_AWID-1:0] PAD_BASE_ADDR = 32'h0;  // pads 0..N-1
  localparam logic [PL_AWID-1:0] MASK_ADDR     = 32'h100;

  // the mask word keeps the dma enable at the bottom of half 1
  localparam int DMA_EN_LSB = PL_HWID;

endpackage

//--- design/gbox_lane_map.sv
`timescale 1ns/1ps

module gbox_lane_map #(
  parameter int GBOX_DWID    = castor_pkg::GBOX_DWID_DEF,
  parameter int FAB_GBOX_NUM = castor_pkg::FAB_GBOX_NUM_DEF
) (
  input  logic                                clk,
  input  logic                                rst_i,
  input  logic                                cfg_done_i,
  input  logic [GBOX_DWID*FAB_GBOX_NUM-1:0]   io_f2a_i,  // fabric pad bits
  input  logic [GBOX_DWID-1:0]                gbox2fab_i [0:FAB_GBOX_NUM-1],
  output logic [GBOX_DWID-1:0]                fab2gbox_o [0:FAB_GBOX_NUM-1],
  output logic [GBOX_DWID*FAB_GBOX_NUM-1:0]   io_a2f_o  // to fabric
);

  localparam int BUS_W = GBOX_DWID * FAB_GBOX_NUM;

  logic [BUS_W-1:0] a2f_nxt;

  // ************************************************************
  // fabric to gearbox
  // ************************************************************
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int k = 0; k < FAB_GBOX_NUM; k++) begin
        fab2gbox_o[k] <= '0;
      end
    end else begin
      for (int k = 0; k < FAB_GBOX_NUM; k++) begin
        if (cfg_done_i) begin
          fab2gbox_o[k] <= io_f2a_i[k*GBOX_DWID +: GBOX_DWID];  // lane k slice
        end else begin
          fab2gbox_o[k] <= '0;  // quiet while configuring
        end
      end
    end
  end

  // ************************************************************
  // gearbox to fabric
  // ************************************************************
  always_comb begin
    for (int k = 0; k < FAB_GBOX_NUM; k++) begin
      a2f_nxt[k*GBOX_DWID +: GBOX_DWID] = gbox2fab_i[k];  // same lane order
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      io_a2f_o <= '0;
    end else begin
      io_a2f_o <= a2f_nxt;  // no cfg_done gating on this side
    end
  end

endmodule

//--- design/io_ctrl_stage.sv
`timescale 1ns/1ps

module io_ctrl_stage #(
  parameter int FAB_GBOX_NUM = castor_pkg::FAB_GBOX_NUM_DEF
) (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic                        cfg_done_i,  // low while configuring
  input  castor_pkg::io_ctrl_t        pad_cfg_i [FAB_GBOX_NUM],
  input  logic [FAB_GBOX_NUM-1:0]     io_oe_dyn_i,  // from fabric logic
  output logic [FAB_GBOX_NUM-1:0]     fab_io_ie_o,
  output logic [FAB_GBOX_NUM-1:0]     fab_io_oe_o,
  output logic [FAB_GBOX_NUM-1:0]     fab_io_pe_o,
  output logic [FAB_GBOX_NUM-1:0]     fab_io_pud_o,
  output logic [FAB_GBOX_NUM*2-1:0]   fab_io_aic_o,
  output logic [FAB_GBOX_NUM*2-1:0]   fab_io_ds_o,
  output logic [FAB_GBOX_NUM*2-1:0]   fab_io_sr_o,
  output logic [FAB_GBOX_NUM*2-1:0]   fab_io_mc_o
);

  logic [FAB_GBOX_NUM-1:0] oe_nxt;
  logic [FAB_GBOX_NUM-1:0] ie_nxt;

  // ************************************************************
  // enables, both held off until configuration is done
  // ************************************************************
  always_comb begin
    for (int i = 0; i < FAB_GBOX_NUM; i++) begin
      oe_nxt[i] = cfg_done_i & pad_cfg_i[i].oe_en & io_oe_dyn_i[i];
      ie_nxt[i] = cfg_done_i & pad_cfg_i[i].ie;  // pad stays HiZ otherwise
    end
  end

  // ************************************************************
  // IO cell bus registers
  // ************************************************************
  always_ff @(posedge clk) begin
    if (rst_i) begin
      fab_io_ie_o  <= '0;
      fab_io_oe_o  <= '0;
      fab_io_pe_o  <= '0;
      fab_io_pud_o <= '0;
      fab_io_aic_o <= '0;
      fab_io_ds_o  <= '0;
      fab_io_sr_o  <= '0;
      fab_io_mc_o  <= '0;
    end else begin
      fab_io_ie_o <= ie_nxt;
      fab_io_oe_o <= oe_nxt;
      for (int i = 0; i < FAB_GBOX_NUM; i++) begin
        fab_io_pe_o[i]       <= pad_cfg_i[i].pe;
        fab_io_pud_o[i]      <= pad_cfg_i[i].pud;
        fab_io_aic_o[2*i +: 2] <= pad_cfg_i[i].aic;  // pad i owns bits 2i+1:2i
        fab_io_ds_o[2*i +: 2]  <= pad_cfg_i[i].ds;
        fab_io_sr_o[2*i +: 2]  <= pad_cfg_i[i].sr;
        fab_io_mc_o[2*i +: 2]  <= pad_cfg_i[i].mc;
      end
    end
  end

endmodule

//--- design/irq_dma_bridge.sv
`timescale 1ns/1ps

module irq_dma_bridge (
  input  logic                                 clk,
  input  logic                                 rst_i,
  input  logic                                 cfg_done_i,
  input  logic [castor_pkg::IRQ_SRC_NUM-1:0]   irq_mask_i,
  input  logic [castor_pkg::DMA_NUM-1:0]       dma_en_i,
  input  logic [castor_pkg::IRQ_SRC_NUM-1:0]   fab_irq_i,      // from fabric
  input  logic [castor_pkg::IRQ_SET_NUM-1:0]   fab_irq_clr_i,  // pulses
  input  logic [castor_pkg::DMA_NUM-1:0]       fab_dma_req_i,  // pulses
  input  logic [castor_pkg::IRQ_SET_NUM-1:0]   a2f_irq_set_i,  // from SoC, pulses
  input  logic [castor_pkg::DMA_NUM-1:0]       a2f_dma_ack_i,  // from SoC, pulses
  output logic [castor_pkg::IRQ_SRC_NUM-1:0]   f2a_irq_src_o,
  output logic [castor_pkg::IRQ_SET_NUM-1:0]   fab_irq_pend_o,
  output logic [castor_pkg::DMA_NUM-1:0]       f2a_dma_req_o
);
  import castor_pkg::*;

  logic [IRQ_SRC_NUM-1:0] src_nxt;
  logic [IRQ_SET_NUM-1:0] pend_nxt;
  logic [DMA_NUM-1:0]     dma_set;
  logic [DMA_NUM-1:0]     dma_nxt;

  // ************************************************************
  // fabric interrupts to SoC
  // ************************************************************
  assign src_nxt = cfg_done_i ? (fab_irq_i & irq_mask_i) : '0;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      f2a_irq_src_o <= '0;
    end else begin
      f2a_irq_src_o <= src_nxt;
    end
  end

  // ************************************************************
  // SoC interrupts to fabric, sticky until cleared
  // ************************************************************
  // a set in the same cycle as a clear keeps the bit
  assign pend_nxt = a2f_irq_set_i | (fab_irq_pend_o & ~fab_irq_clr_i);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      fab_irq_pend_o <= '0;
    end else begin
      fab_irq_pend_o <= pend_nxt;
    end
  end

  // ************************************************************
  // dma requests, held until acknowledged
  // ************************************************************
  assign dma_set = fab_dma_req_i & dma_en_i;  // disabled channels dropped
  assign dma_nxt = dma_set | (f2a_dma_req_o & ~a2f_dma_ack_i);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      f2a_dma_req_o <= '0;
    end else begin
      f2a_dma_req_o <= dma_nxt;
    end
  end

endmodule

//--- design/pl_cfg_bank.sv
`timescale 1ns/1ps

module pl_cfg_bank #(
  parameter int FAB_GBOX_NUM = castor_pkg::FAB_GBOX_NUM_DEF
) (
  input  logic                                 clk,
  input  logic                                 rst_i,
  input  castor_pkg::pl_cmd_t                  pl_cmd_i,
  output logic [castor_pkg::PL_DWID-1:0]       pl_data_o,
  output castor_pkg::io_ctrl_t                 pad_cfg_o [FAB_GBOX_NUM],
  output logic [castor_pkg::IRQ_SRC_NUM-1:0]   irq_mask_o,
  output logic [castor_pkg::DMA_NUM-1:0]       dma_en_o
);
  import castor_pkg::*;

  logic [FAB_GBOX_NUM-1:0] pad_hit;  // one-hot pad word decode
  logic                    mask_hit;
  logic                    wr_lo;
  logic                    wr_hi;
  logic                    rd_req;
  logic [PL_DWID-1:0]      rd_word;

  io_ctrl_t                pad_q [FAB_GBOX_NUM];
  logic [IRQ_SRC_NUM-1:0]  mask_q;
  logic [DMA_NUM-1:0]      dma_q;

  // ************************************************************
  // address decode
  // ************************************************************
  always_comb begin
    for (int i = 0; i < FAB_GBOX_NUM; i++) begin
      pad_hit[i] = (pl_cmd_i.addr == PAD_BASE_ADDR + PL_AWID'(i));
    end
  end

  assign mask_hit = (pl_cmd_i.addr == MASK_ADDR);
  assign wr_lo    = pl_cmd_i.ena & pl_cmd_i.wen[0];  // bits 17:0
  assign wr_hi    = pl_cmd_i.ena & pl_cmd_i.wen[1];  // bits 35:18
  assign rd_req   = pl_cmd_i.ena & pl_cmd_i.ren;

  // ************************************************************
  // register writes
  // ************************************************************
  always_ff @(posedge clk) begin
    if (rst_i || pl_cmd_i.init) begin
      for (int i = 0; i < FAB_GBOX_NUM; i++) begin
        pad_q[i] <= '0;
      end
      mask_q <= '0;
      dma_q  <= '0;
    end else begin
      for (int i = 0; i < FAB_GBOX_NUM; i++) begin
        if (wr_lo && pad_hit[i]) begin
          pad_q[i] <= io_ctrl_t'(pl_cmd_i.data[IO_CTRL_W-1:0]);  // half 1 unused
        end
      end
      if (wr_lo && mask_hit) begin
        mask_q <= pl_cmd_i.data[IRQ_SRC_NUM-1:0];
      end
      if (wr_hi && mask_hit) begin
        dma_q <= pl_cmd_i.data[DMA_EN_LSB +: DMA_NUM];
      end
    end
  end

  // ************************************************************
  // readback
  // ************************************************************
  always_comb begin
    rd_word = '0;  // unaddressed reads give zero
    for (int i = 0; i < FAB_GBOX_NUM; i++) begin
      if (pad_hit[i]) begin
        rd_word[IO_CTRL_W-1:0] = pad_q[i];
      end
    end
    if (mask_hit) begin
      rd_word[IRQ_SRC_NUM-1:0]         = mask_q;
      rd_word[DMA_EN_LSB +: DMA_NUM]   = dma_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pl_data_o <= '0;
    end else if (rd_req) begin
      pl_data_o <= rd_word;  // held until the next read
    end
  end

  assign pad_cfg_o  = pad_q;
  assign irq_mask_o = mask_q;
  assign dma_en_o   = dma_q;

endmodule

//--- files.f
+incdir+include
design/castor_pkg.sv
design/pl_cfg_bank.sv
design/io_ctrl_stage.sv
design/gbox_lane_map.sv
design/irq_dma_bridge.sv
design/castor_map_top.sv
verification/tb_castor_map.sv

//--- run_sim.sh
#!/bin/sh
# build and run the castor map testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  -f files.f --top-module tb_castor_map -o sim_castor
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_castor)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1

//--- include/tb_castor_ref.svh
`ifndef TB_CASTOR_REF_SVH
`define TB_CASTOR_REF_SVH

// ************************************************************
// random source
// ************************************************************
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// expected fab2gbox lane k for one io_f2a vector
function automatic logic [castor_pkg::GBOX_DWID_DEF-1:0] ref_f2gbox_lane(
    input logic [castor_pkg::GBOX_DWID_DEF*castor_pkg::FAB_GBOX_NUM_DEF-1:0] f2a,
    input int k, input logic cfg_done);
  if (!cfg_done) return '0;
  return f2a[k*castor_pkg::GBOX_DWID_DEF +: castor_pkg::GBOX_DWID_DEF];
endfunction

// expected pad outputs, the oe_en field carries the expected oe
function automatic castor_pkg::io_ctrl_t ref_io_pad(
    input castor_pkg::io_ctrl_t cfg, input logic oe_dyn, input logic cfg_done);
  castor_pkg::io_ctrl_t r;
  r       = cfg;
  r.oe_en = cfg_done & cfg.oe_en & oe_dyn;
  r.ie    = cfg_done & cfg.ie;
  return r;
endfunction

// readback words
function automatic logic [castor_pkg::PL_DWID-1:0] ref_pad_rd(
    input castor_pkg::io_ctrl_t cfg);
  return {{(castor_pkg::PL_DWID-castor_pkg::IO_CTRL_W){1'b0}}, cfg};
endfunction

function automatic logic [castor_pkg::PL_DWID-1:0] ref_mask_rd(
    input logic [castor_pkg::IRQ_SRC_NUM-1:0] mask,
    input logic [castor_pkg::DMA_NUM-1:0] dma_en);
  return {14'h0, dma_en, 2'b00, mask};  // dma enable at bit 18
endfunction

`endif

//--- verification/tb_castor_map.sv
`timescale 1ns/1ps

module tb_castor_map;
  import castor_pkg::*;

  `include "tb_castor_ref.svh"

  localparam int GW    = GBOX_DWID_DEF;
  localparam int NL    = FAB_GBOX_NUM_DEF;
  localparam int BUS_W = GW * NL;
  localparam int TMO   = 50;  // cycles allowed per wait

  logic                   clk = 1'b0;
  logic                   rst_i;
  logic                   cfg_done_i;
  logic                   pl_init_i;
  logic                   pl_ena_i;
  logic [1:0]             pl_wen_i;
  logic                   pl_ren_i;
  logic [PL_AWID-1:0]     pl_addr_i;
  logic [PL_DWID-1:0]     pl_data_i;
  logic [PL_DWID-1:0]     pl_data_o;
  logic [BUS_W-1:0]       io_f2a_i;
  logic [NL-1:0]          io_oe_dyn_i;
  logic [IRQ_SRC_NUM-1:0] fab_irq_i;
  logic [DMA_NUM-1:0]     fab_dma_req_i;
  logic [IRQ_SET_NUM-1:0] fab_irq_clr_i;
  logic [BUS_W-1:0]       io_a2f_o;
  logic [IRQ_SET_NUM-1:0] fab_irq_pend_o;
  logic [GW-1:0]          gbox2fab [0:NL-1];
  logic [GW-1:0]          fab2gbox [0:NL-1];
  logic [IRQ_SET_NUM-1:0] a2f_irq_set_i;
  logic [DMA_NUM-1:0]     a2f_dma_ack_i;
  logic [IRQ_SRC_NUM-1:0] f2a_irq_src_o;
  logic [DMA_NUM-1:0]     f2a_dma_req_o;
  logic [NL-1:0]          fab_io_ie_o;
  logic [NL-1:0]          fab_io_oe_o;
  logic [NL-1:0]          fab_io_pe_o;
  logic [NL-1:0]          fab_io_pud_o;
  logic [NL*2-1:0]        fab_io_aic_o;
  logic [NL*2-1:0]        fab_io_ds_o;
  logic [NL*2-1:0]        fab_io_sr_o;
  logic [NL*2-1:0]        fab_io_mc_o;

  // expected register values after the next edge
  logic                   exp_valid = 1'b0;
  logic [GW-1:0]          exp_lane [0:NL-1];
  logic [BUS_W-1:0]       exp_a2f;
  logic [NL-1:0]          exp_ie, exp_oe, exp_pe, exp_pud;
  logic [NL*2-1:0]        exp_aic, exp_ds, exp_sr, exp_mc;
  logic [IRQ_SRC_NUM-1:0] exp_src;
  logic [IRQ_SET_NUM-1:0] exp_pend;
  logic [DMA_NUM-1:0]     exp_dma;
  logic [PL_DWID-1:0]     exp_rd;
  io_ctrl_t               m_pad [0:NL-1];  // bank contents
  logic [IRQ_SRC_NUM-1:0] m_mask;
  logic [DMA_NUM-1:0]     m_dma_en;

  logic [31:0] rnd_state = 32'h653e_109a;
  int          err_cnt   = 0;
  int          chk_cnt   = 0;
  int          test_num  = 0;
  int          test_err0 = 0;
  string       test_name;

  always #10 clk = ~clk;

  castor_map_top #(.GBOX_DWID(GW), .FAB_GBOX_NUM(NL)) u_dut (
    .clk            (clk),
    .rst_i          (rst_i),
    .cfg_done_i     (cfg_done_i),
    .pl_init_i      (pl_init_i),
    .pl_ena_i       (pl_ena_i),
    .pl_wen_i       (pl_wen_i),
    .pl_ren_i       (pl_ren_i),
    .pl_addr_i      (pl_addr_i),
    .pl_data_i      (pl_data_i),
    .pl_data_o      (pl_data_o),
    .io_f2a_i       (io_f2a_i),
    .io_oe_dyn_i    (io_oe_dyn_i),
    .fab_irq_i      (fab_irq_i),
    .fab_dma_req_i  (fab_dma_req_i),
    .fab_irq_clr_i  (fab_irq_clr_i),
    .io_a2f_o       (io_a2f_o),
    .fab_irq_pend_o (fab_irq_pend_o),
    .gbox2fab_i     (gbox2fab),
    .fab2gbox_o     (fab2gbox),
    .a2f_irq_set_i  (a2f_irq_set_i),
    .a2f_dma_ack_i  (a2f_dma_ack_i),
    .f2a_irq_src_o  (f2a_irq_src_o),
    .f2a_dma_req_o  (f2a_dma_req_o),
    .fab_io_ie_o    (fab_io_ie_o),
    .fab_io_oe_o    (fab_io_oe_o),
    .fab_io_pe_o    (fab_io_pe_o),
    .fab_io_pud_o   (fab_io_pud_o),
    .fab_io_aic_o   (fab_io_aic_o),
    .fab_io_ds_o    (fab_io_ds_o),
    .fab_io_sr_o    (fab_io_sr_o),
    .fab_io_mc_o    (fab_io_mc_o)
  );

  task check(input string name, input logic [63:0] got, input logic [63:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // ************************************************************
  // expected values for the coming edge
  // ************************************************************
  task automatic predict_next();
    io_ctrl_t           r;
    logic [PL_DWID-1:0] rd;
    if (rst_i) begin
      for (int k = 0; k < NL; k++) begin
        exp_lane[k] = '0;
        m_pad[k]    = '0;
      end
      {exp_a2f, exp_ie, exp_oe, exp_pe, exp_pud} = '0;
      {exp_aic, exp_ds, exp_sr, exp_mc} = '0;
      {exp_src, exp_pend, exp_dma, exp_rd, m_mask, m_dma_en} = '0;
    end else begin
      for (int k = 0; k < NL; k++) begin
        exp_lane[k]               = ref_f2gbox_lane(io_f2a_i, k, cfg_done_i);
        exp_a2f[k*GW +: GW]       = gbox2fab[k];
        r                         = ref_io_pad(m_pad[k], io_oe_dyn_i[k], cfg_done_i);
        exp_ie[k]                 = r.ie;
        exp_oe[k]                 = r.oe_en;  // carries the expected oe
        exp_pe[k]                 = r.pe;
        exp_pud[k]                = r.pud;
        exp_aic[2*k +: 2]         = r.aic;
        exp_ds[2*k +: 2]          = r.ds;
        exp_sr[2*k +: 2]          = r.sr;
        exp_mc[2*k +: 2]          = r.mc;
      end
      exp_src  = cfg_done_i ? (fab_irq_i & m_mask) : '0;
      exp_pend = a2f_irq_set_i | (exp_pend & ~fab_irq_clr_i);  // set wins
      exp_dma  = (fab_dma_req_i & m_dma_en) | (exp_dma & ~a2f_dma_ack_i);
      if (pl_ena_i && pl_ren_i) begin
        rd = '0;  // unaddressed
        for (int k = 0; k < NL; k++) begin
          if (pl_addr_i == PL_AWID'(k)) rd = ref_pad_rd(m_pad[k]);
        end
        if (pl_addr_i == MASK_ADDR) rd = ref_mask_rd(m_mask, m_dma_en);
        exp_rd = rd;
      end
      // bank update comes last, reads see the old contents
      if (pl_init_i) begin
        for (int k = 0; k < NL; k++) m_pad[k] = '0;
        m_mask   = '0;
        m_dma_en = '0;
      end else if (pl_ena_i) begin
        for (int k = 0; k < NL; k++) begin
          if (pl_wen_i[0] && pl_addr_i == PL_AWID'(k)) m_pad[k] = io_ctrl_t'(pl_data_i[11:0]);
        end
        if (pl_addr_i == MASK_ADDR && pl_wen_i[0]) m_mask   = pl_data_i[15:0];
        if (pl_addr_i == MASK_ADDR && pl_wen_i[1]) m_dma_en = pl_data_i[21:18];
      end
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (exp_valid) begin
      for (int k = 0; k < NL; k++) begin
        check($sformatf("fab2gbox_o[%0d]", k), 64'(fab2gbox[k]), 64'(exp_lane[k]));
      end
      check("io_a2f_o", 64'(io_a2f_o), 64'(exp_a2f));
      check("fab_io_ie_o", 64'(fab_io_ie_o), 64'(exp_ie));
      check("fab_io_oe_o", 64'(fab_io_oe_o), 64'(exp_oe));
      check("fab_io_pe_o", 64'(fab_io_pe_o), 64'(exp_pe));
      check("fab_io_pud_o", 64'(fab_io_pud_o), 64'(exp_pud));
      check("fab_io_aic_o", 64'(fab_io_aic_o), 64'(exp_aic));
      check("fab_io_ds_o", 64'(fab_io_ds_o), 64'(exp_ds));
      check("fab_io_sr_o", 64'(fab_io_sr_o), 64'(exp_sr));
      check("fab_io_mc_o", 64'(fab_io_mc_o), 64'(exp_mc));
      check("f2a_irq_src_o", 64'(f2a_irq_src_o), 64'(exp_src));
      check("fab_irq_pend_o", 64'(fab_irq_pend_o), 64'(exp_pend));
      check("f2a_dma_req_o", 64'(f2a_dma_req_o), 64'(exp_dma));
      check("pl_data_o", 64'(pl_data_o), 64'(exp_rd));
    end
    predict_next();
    exp_valid = 1'b1;
  end

  // ************************************************************
  // stimulus helpers
  // ************************************************************
  function logic [31:0] next_rand();
    rnd_state = xorshift32(rnd_state);
    return rnd_state;
  endfunction

  function logic [PL_DWID-1:0] rand_word();
    logic [31:0] lo;
    logic [31:0] hi;
    lo = next_rand();
    hi = next_rand();
    return {hi[3:0], lo};
  endfunction

  task next_cycle();
    @(posedge clk);
    #2;  // inputs change just after the edge
  endtask

  task idle(input int n);
    repeat (n) next_cycle();
  endtask

  task pl_write(input logic [PL_AWID-1:0] addr, input logic [PL_DWID-1:0] data,
                input logic [1:0] wen);
    pl_ena_i  = 1'b1;
    pl_wen_i  = wen;
    pl_addr_i = addr;
    pl_data_i = data;
    next_cycle();
    pl_ena_i  = 1'b0;
    pl_wen_i  = 2'b00;
  endtask

  task pl_read(input logic [PL_AWID-1:0] addr);
    pl_ena_i  = 1'b1;
    pl_ren_i  = 1'b1;
    pl_addr_i = addr;
    next_cycle();
    pl_ena_i  = 1'b0;
    pl_ren_i  = 1'b0;
  endtask

  task pl_clear();
    pl_init_i = 1'b1;
    next_cycle();
    pl_init_i = 1'b0;
  endtask

  task abort_run(input string why);
    $display("timeout: %s", why);
    $display("Something failed");
    $finish;
  endtask

  task wait_pend_value(input logic [IRQ_SET_NUM-1:0] val);
    int n;
    n = 0;
    while (fab_irq_pend_o !== val && n < TMO) begin
      next_cycle();
      n++;
    end
    if (fab_irq_pend_o !== val) abort_run($sformatf("fab_irq_pend_o never reached 0x%0h", val));
  endtask

  task wait_dma_value(input logic [DMA_NUM-1:0] val);
    int n;
    n = 0;
    while (f2a_dma_req_o !== val && n < TMO) begin
      next_cycle();
      n++;
    end
    if (f2a_dma_req_o !== val) abort_run($sformatf("f2a_dma_req_o never reached 0x%0h", val));
  endtask

  task begin_test(input string name);
    test_num++;
    test_name = name;
    test_err0 = err_cnt;
  endtask

  task end_test();
    idle(2);  // let the compare process see the last cycle
    $display("test %0d %s: %s (%0d errors)", test_num, test_name,
             (err_cnt == test_err0) ? "passed" : "failed", err_cnt - test_err0);
  endtask

  // ************************************************************
  // tests
  // ************************************************************
  initial begin
    rst_i = 1'b1;
    cfg_done_i = 1'b0;
    {pl_init_i, pl_ena_i, pl_wen_i, pl_ren_i, pl_addr_i, pl_data_i} = '0;
    {io_f2a_i, io_oe_dyn_i, fab_irq_i, fab_dma_req_i, fab_irq_clr_i} = '0;
    {a2f_irq_set_i, a2f_dma_ack_i} = '0;
    for (int k = 0; k < NL; k++) gbox2fab[k] = '0;
    idle(4);
    rst_i = 1'b0;

    begin_test("reset_state");
    for (int a = 0; a < NL; a++) pl_read(PL_AWID'(a));
    pl_read(MASK_ADDR);
    pl_read(32'h55);
    end_test();

    begin_test("pl_access");
    for (int w = 0; w < 4; w++) begin
      for (int a = 0; a <= NL; a++) begin
        pl_write((a == NL) ? MASK_ADDR : PL_AWID'(a), rand_word(), 2'(w));
        pl_read((a == NL) ? MASK_ADDR : PL_AWID'(a));
      end
    end
    pl_read(PL_AWID'(NL));  // just past the pads
    pl_read(32'h101);
    pl_clear();
    for (int a = 0; a < NL; a++) pl_read(PL_AWID'(a));
    pl_read(MASK_ADDR);
    end_test();

    begin_test("gbox_map");
    cfg_done_i = 1'b1;
    for (int c = 0; c < 30; c++) begin
      if (c == 20) cfg_done_i = 1'b0;  // fab2gbox must go quiet
      io_f2a_i = BUS_W'(next_rand());
      for (int k = 0; k < NL; k++) gbox2fab[k] = GW'(next_rand());
      next_cycle();
    end
    end_test();

    begin_test("io_ctrl");
    for (int a = 0; a < NL; a++) pl_write(PL_AWID'(a), rand_word(), 2'b01);
    cfg_done_i = 1'b1;
    for (int c = 0; c < 30; c++) begin
      if (c == 10) pl_write(PL_AWID'(c % NL), rand_word(), 2'b11);
      if (c == 22) cfg_done_i = 1'b0;
      io_oe_dyn_i = NL'(next_rand());
      next_cycle();
    end
    end_test();

    begin_test("interrupts");
    pl_write(MASK_ADDR, {20'h0, 16'(next_rand())}, 2'b01);
    cfg_done_i = 1'b1;
    for (int c = 0; c < 25; c++) begin
      if (c == 18) cfg_done_i = 1'b0;
      fab_irq_i = IRQ_SRC_NUM'(next_rand());
      next_cycle();
    end
    fab_irq_i = '0;
    a2f_irq_set_i = 12'h0a5;
    next_cycle();
    a2f_irq_set_i = '0;
    wait_pend_value(12'h0a5);
    idle(3);  // sticky
    fab_irq_clr_i = 12'h005;
    next_cycle();
    fab_irq_clr_i = '0;
    wait_pend_value(12'h0a0);
    a2f_irq_set_i = 12'h020;  // set and clear together
    fab_irq_clr_i = 12'h0a0;
    next_cycle();
    {a2f_irq_set_i, fab_irq_clr_i} = '0;
    wait_pend_value(12'h020);
    fab_irq_clr_i = 12'hfff;
    next_cycle();
    fab_irq_clr_i = '0;
    wait_pend_value(12'h000);
    end_test();

    begin_test("dma");
    pl_write(MASK_ADDR, {14'h0, 4'b0101, 18'h0}, 2'b10);  // channels 0 and 2
    fab_dma_req_i = 4'b0001;
    next_cycle();
    fab_dma_req_i = '0;
    wait_dma_value(4'b0001);
    idle(4);
    a2f_dma_ack_i = 4'b0001;
    next_cycle();
    a2f_dma_ack_i = '0;
    wait_dma_value(4'b0000);
    fab_dma_req_i = 4'b0010;  // disabled channel
    next_cycle();
    fab_dma_req_i = '0;
    idle(3);
    fab_dma_req_i = 4'b0100;
    next_cycle();
    wait_dma_value(4'b0100);
    a2f_dma_ack_i = 4'b0100;  // request keeps the bit
    next_cycle();
    {fab_dma_req_i, a2f_dma_ack_i} = '0;
    idle(2);
    a2f_dma_ack_i = 4'b0100;
    next_cycle();
    a2f_dma_ack_i = '0;
    wait_dma_value(4'b0000);
    end_test();

    $display("summary: %0d tests, %0d checks, %0d errors", test_num, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
